//--- hw/lgv_mem_pkg.sv
`default_nettype none

package lgv_mem_pkg;

	// RAM region start in the 32-bit address space
	localparam logic [31:0] RAM_BASE = 32'h2000_0000;

	// Doubleword index width, 1024 x 8 bytes
	localparam int RAM_ADDR_WIDTH = 10;

	// Byte address bits covered by the RAM region
	localparam int RAM_BYTE_BITS = RAM_ADDR_WIDTH + 3;

	// Access width of a load or store
	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_HALF,
		SZ_WORD,
		SZ_DWORD
	} mem_size_e;

endpackage

`default_nettype wire

//--- hw/lgv_isa_pkg.sv
`default_nettype none

package lgv_isa_pkg;

	// Datapath width
	localparam int XLEN = 64;

	// Hardwired zero register
	localparam logic [4:0] REG_ZERO = 5'd31;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_AND,
		ALU_ORR,
		ALU_EOR,
		ALU_ADD,
		ALU_SUB,
		ALU_LSL,
		ALU_LSR,
		ALU_PASS_B
	} alu_op_e;

	// Data bus source
	typedef enum logic [1:0] {
		DS_ALU,
		DS_REG_B,
		DS_PC,
		DS_MEM
	} data_src_e;

	// Address bus source
	typedef enum logic {
		AS_ALU,
		AS_PC
	} addr_src_e;

	// Program counter operation
	typedef enum logic [1:0] {
		PC_HOLD,
		PC_INCR,
		PC_LOAD_A,
		PC_BRANCH
	} pc_op_e;

	// Constant generator mode
	typedef enum logic [1:0] {
		CG_ZERO_EXT,
		CG_SIGN_EXT,
		CG_SHIFT16
	} const_mode_e;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	// One decoded micro-instruction
	typedef struct packed {
		logic [4:0]              da;
		logic [4:0]              sa;
		logic [4:0]              sb;
		logic                    rw;
		logic                    b_sel;
		alu_op_e                 fs;
		logic                    c0;
		logic                    sl;
		logic                    il;
		data_src_e               ds;
		addr_src_e               as;
		pc_op_e                  ps;
		const_mode_e             cgs;
		logic                    mw;
		lgv_mem_pkg::mem_size_e  size;
		logic [15:0]             imm;
	} ctrl_word_t;

	// Per-word result as seen after completion
	typedef struct packed {
		logic [XLEN-1:0] data;
		logic [31:0]     addr;
		flags_t          flags;
		flags_t          status;
		logic [31:0]     pc;
	} dp_result_t;

endpackage

`default_nettype wire

//--- hw/lgv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lgv_regfile (
	input  wire logic                          clock,
	input  wire logic                          arst_n,
	input  wire logic [4:0]                    sa,
	input  wire logic [4:0]                    sb,
	input  wire logic [4:0]                    da,
	input  wire logic                          we,
	input  wire logic [lgv_isa_pkg::XLEN-1:0]  wdata,
	output logic [lgv_isa_pkg::XLEN-1:0]       a,
	output logic [lgv_isa_pkg::XLEN-1:0]       b
);

	import lgv_isa_pkg::*;

	// Only x0..x30 have storage
	logic [XLEN-1:0] regs [0:30];

	// Writes blocked while reset is asserted
	logic wr_en;

	assign wr_en = we && arst_n && (da != REG_ZERO);

	always_ff @(posedge clock) begin
		if (wr_en) begin
			regs[da] <= wdata;
		end
	end

	// Combinational read ports, XZR returns zero
	always_comb begin
		if (sa == REG_ZERO) begin
			a = '0;
		end else begin
			a = regs[sa];
		end
		if (sb == REG_ZERO) begin
			b = '0;
		end else begin
			b = regs[sb];
		end
	end

endmodule

`default_nettype wire

//--- hw/lgv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module lgv_alu (
	input  wire logic [lgv_isa_pkg::XLEN-1:0]  a,
	input  wire logic [lgv_isa_pkg::XLEN-1:0]  b,
	input  wire lgv_isa_pkg::alu_op_e          fs,
	input  wire logic                          c0,
	output logic [lgv_isa_pkg::XLEN-1:0]       f,
	output lgv_isa_pkg::flags_t                flags
);

	import lgv_isa_pkg::*;

	// Shared adder for add and subtract
	logic              is_sub;
	logic [XLEN-1:0]   b_eff;
	logic              cin;
	logic [XLEN:0]     sum;
	logic              ovf;

	// Shift amount from low six bits of b
	logic [5:0]        shamt;

	assign is_sub = (fs == ALU_SUB);

	// Subtract as a + ~b + 1
	assign b_eff = is_sub ? ~b : b;
	assign cin   = is_sub ? 1'b1 : c0;

	assign sum = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, cin};

	// Signed overflow: like-signed operands, result sign flipped
	assign ovf = (a[XLEN-1] == b_eff[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);

	assign shamt = b[5:0];

	always_comb begin
		f = '0;
		unique case (fs)
			ALU_AND: begin
				f = a & b;
			end
			ALU_ORR: begin
				f = a | b;
			end
			ALU_EOR: begin
				f = a ^ b;
			end
			ALU_ADD, ALU_SUB: begin
				f = sum[XLEN-1:0];
			end
			ALU_LSL: begin
				f = a << shamt;
			end
			ALU_LSR: begin
				f = a >> shamt;
			end
			ALU_PASS_B: begin
				f = b;
			end
			default: begin
				f = '0;
			end
		endcase
	end

	always_comb begin
		flags.n = f[XLEN-1];
		flags.z = (f == '0);
		// Carry and overflow only meaningful for the adder
		if (fs == ALU_ADD || fs == ALU_SUB) begin
			flags.c = sum[XLEN];
			flags.v = ovf;
		end else begin
			flags.c = 1'b0;
			flags.v = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/lgv_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lgv_pc_unit (
	input  wire logic                          clock,
	input  wire logic                          arst_n,
	input  wire logic                          advance,
	input  wire lgv_isa_pkg::pc_op_e           ps,
	input  wire logic [lgv_isa_pkg::XLEN-1:0]  load_val,
	input  wire logic [lgv_isa_pkg::XLEN-1:0]  offset,
	output logic [31:0]                        pc
);

	import lgv_isa_pkg::*;

	logic [31:0] pc_next;

	// Next PC per operation select
	always_comb begin
		unique case (ps)
			PC_HOLD: begin
				pc_next = pc;
			end
			PC_INCR: begin
				pc_next = pc + 32'd4;
			end
			PC_LOAD_A: begin
				pc_next = load_val[31:0];
			end
			PC_BRANCH: begin
				// Offset already scaled to bytes
				pc_next = pc + offset[31:0];
			end
			default: begin
				pc_next = pc;
			end
		endcase
	end

	// Only moves on the edge a word completes
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (advance) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

//--- hw/lgv_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lgv_ram (
	input  wire logic                          clock,
	input  wire logic                          wr,
	input  wire logic                          rd,
	input  wire logic [31:0]                   addr,
	input  wire logic [lgv_isa_pkg::XLEN-1:0]  wdata,
	input  wire lgv_mem_pkg::mem_size_e        size,
	output logic [lgv_isa_pkg::XLEN-1:0]       rdata
);

	import lgv_isa_pkg::*;
	import lgv_mem_pkg::*;

	logic [XLEN-1:0] mem [0:(1 << RAM_ADDR_WIDTH)-1];

	logic                       in_region;
	logic [RAM_ADDR_WIDTH-1:0]  idx;
	logic [2:0]                 lane;
	logic [7:0]                 be;
	logic [XLEN-1:0]            wdata_sh;

	// Read side, captured with the request
	logic [XLEN-1:0]            rd_word_q;
	logic [2:0]                 rd_lane_q;
	mem_size_e                  rd_size_q;
	logic                       rd_hit_q;
	logic [XLEN-1:0]            rd_shift;

	// Region hit on the upper address bits
	assign in_region = (addr[31:RAM_BYTE_BITS] == RAM_BASE[31:RAM_BYTE_BITS]);
	assign idx = addr[RAM_BYTE_BITS-1:3];

	// Aligned lane and byte enables by access size
	always_comb begin
		unique case (size)
			SZ_BYTE: begin
				lane = addr[2:0];
				be   = 8'h01 << lane;
			end
			SZ_HALF: begin
				lane = {addr[2:1], 1'b0};
				be   = 8'h03 << lane;
			end
			SZ_WORD: begin
				lane = {addr[2], 2'b00};
				be   = 8'h0f << lane;
			end
			default: begin
				lane = 3'd0;
				be   = 8'hff;
			end
		endcase
	end

	// Low bytes of store data moved to their lane
	assign wdata_sh = wdata << {lane, 3'b000};

	always_ff @(posedge clock) begin
		if (wr && in_region) begin
			for (int i = 0; i < 8; i++) begin
				if (be[i]) begin
					mem[idx][8*i +: 8] <= wdata_sh[8*i +: 8];
				end
			end
		end
		if (rd) begin
			rd_word_q <= mem[idx];
			rd_lane_q <= lane;
			rd_size_q <= size;
			rd_hit_q  <= in_region;
		end
	end

	assign rd_shift = rd_word_q >> {rd_lane_q, 3'b000};

	// Zero-extend to the access size, zero off-region
	always_comb begin
		unique case (rd_size_q)
			SZ_BYTE:  rdata = {{(XLEN-8){1'b0}}, rd_shift[7:0]};
			SZ_HALF:  rdata = {{(XLEN-16){1'b0}}, rd_shift[15:0]};
			SZ_WORD:  rdata = {{(XLEN-32){1'b0}}, rd_shift[31:0]};
			default:  rdata = rd_shift;
		endcase
		if (!rd_hit_q) begin
			rdata = '0;
		end
	end

endmodule

`default_nettype wire

//--- hw/lgv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module lgv_datapath (
	input  wire logic                     clock,
	input  wire logic                     arst_n,
	input  wire lgv_isa_pkg::ctrl_word_t  cw,
	input  wire logic                     cw_valid,
	output logic                          cw_ready,
	output lgv_isa_pkg::dp_result_t       res,
	output logic                          res_valid,
	input  wire logic                     res_ready
);

	import lgv_isa_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_LOAD_WAIT
	} state_e;

	state_e      state_q;
	ctrl_word_t  cw_q;
	// Word being executed this cycle
	ctrl_word_t  cur;

	logic        accept;
	logic        is_load;
	logic        complete;

	logic [XLEN-1:0]  rf_a;
	logic [XLEN-1:0]  rf_b;
	logic [XLEN-1:0]  konst;
	logic [XLEN-1:0]  op_b;
	logic [XLEN-1:0]  alu_f;
	flags_t           alu_flags;
	logic [XLEN-1:0]  ram_rdata;
	logic [31:0]      pc;
	logic [XLEN-1:0]  data_bus;
	logic [31:0]      addr_bus;

	flags_t           status_q;

	// Result payload captured on completion
	logic [XLEN-1:0]  res_data_q;
	logic [31:0]      res_addr_q;
	flags_t           res_flags_q;

	// No new word while loading or while a result is stalled
	assign cw_ready = (state_q == ST_IDLE) && (!res_valid || res_ready);
	assign accept   = cw_valid && cw_ready;

	// Held copy drives the datapath during load wait
	assign cur      = (state_q == ST_LOAD_WAIT) ? cw_q : cw;
	assign is_load  = (cur.ds == DS_MEM);
	assign complete = (accept && !is_load) || (state_q == ST_LOAD_WAIT);

	// Constant generator
	always_comb begin
		unique case (cur.cgs)
			CG_ZERO_EXT: konst = {{(XLEN-16){1'b0}}, cur.imm};
			CG_SIGN_EXT: konst = {{(XLEN-16){cur.imm[15]}}, cur.imm};
			CG_SHIFT16:  konst = {{(XLEN-32){1'b0}}, cur.imm, 16'h0000};
			default:     konst = '0;
		endcase
	end

	assign op_b = cur.b_sel ? konst : rf_b;

	lgv_regfile lgv_regfile_i (
		.clock  (clock),
		.arst_n (arst_n),
		.sa     (cur.sa),
		.sb     (cur.sb),
		.da     (cur.da),
		.we     (complete && cur.rw),
		.wdata  (data_bus),
		.a      (rf_a),
		.b      (rf_b)
	);

	lgv_alu lgv_alu_i (
		.a     (rf_a),
		.b     (op_b),
		.fs    (cur.fs),
		.c0    (cur.c0),
		.f     (alu_f),
		.flags (alu_flags)
	);

	// Branch offset in words, scaled to bytes
	lgv_pc_unit lgv_pc_unit_i (
		.clock    (clock),
		.arst_n   (arst_n),
		.advance  (complete),
		.ps       (cur.ps),
		.load_val (rf_a),
		.offset   (konst << 2),
		.pc       (pc)
	);

	// Stores at acceptance, loads issued at acceptance
	lgv_ram lgv_ram_i (
		.clock (clock),
		.wr    (accept && cur.mw && !is_load),
		.rd    (accept && is_load),
		.addr  (addr_bus),
		.wdata (rf_b),
		.size  (cur.size),
		.rdata (ram_rdata)
	);

	// Data bus source
	always_comb begin
		unique case (cur.ds)
			DS_ALU:   data_bus = alu_f;
			DS_REG_B: data_bus = rf_b;
			DS_PC:    data_bus = {{(XLEN-32){1'b0}}, pc};
			default:  data_bus = ram_rdata;
		endcase
	end

	assign addr_bus = (cur.as == AS_PC) ? pc : alu_f[31:0];

	// Load wait FSM, one cycle for the RAM read
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ST_IDLE;
		end else if (accept && is_load) begin
			state_q <= ST_LOAD_WAIT;
		end else if (state_q == ST_LOAD_WAIT) begin
			state_q <= ST_IDLE;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			cw_q <= cw;
		end
	end

	// Status register
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			status_q <= '0;
		end else if (complete) begin
			if (cur.sl) begin
				status_q <= alu_flags;
			end
		end
	end

	// Result valid until taken
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else if (complete) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (complete) begin
			res_data_q  <= data_bus;
			res_addr_q  <= addr_bus;
			res_flags_q <= alu_flags;
		end
	end

	// Status and PC only move on completion, so they hold with the result
	assign res = '{
		data:   res_data_q,
		addr:   res_addr_q,
		flags:  res_flags_q,
		status: status_q,
		pc:     pc
	};

endmodule

`default_nettype wire

//--- verif/lgv_datapath_props.sv
`timescale 1ns/1ps
`default_nettype none

module lgv_datapath_props (
	input wire logic                     clock,
	input wire logic                     arst_n,
	input wire lgv_isa_pkg::ctrl_word_t  cw,
	input wire logic                     cw_valid,
	input wire logic                     cw_ready,
	input wire lgv_isa_pkg::dp_result_t  res,
	input wire logic                     res_valid,
	input wire logic                     res_ready
);

	import lgv_isa_pkg::*;

	// Read by the testbench summary
	int fail_count = 0;

	// Result payload frozen under back-pressure
	res_hold_a: assert property (@(posedge clock) disable iff (!arst_n)
		res_valid && !res_ready |=> $stable(res))
	else begin
		fail_count++;
		$error("res changed while the result was stalled");
	end

	// One-cycle bubble behind an accepted load
	load_wait_a: assert property (@(posedge clock) disable iff (!arst_n)
		cw_valid && cw_ready && (cw.ds == DS_MEM) |=> !cw_ready)
	else begin
		fail_count++;
		$error("cw_ready high in the cycle after a load was accepted");
	end

	// A stalled result stays valid until taken
	valid_hold_a: assert property (@(posedge clock) disable iff (!arst_n)
		res_valid && !res_ready |=> res_valid)
	else begin
		fail_count++;
		$error("res_valid dropped before the result was taken");
	end

	// Clean handshake state out of reset
	reset_a: assert property (@(posedge clock) $rose(arst_n) |-> !res_valid)
	else begin
		fail_count++;
		$error("res_valid high after reset");
	end

endmodule

bind lgv_datapath lgv_datapath_props lgv_datapath_props_i (
	.clock     (clock),
	.arst_n    (arst_n),
	.cw        (cw),
	.cw_valid  (cw_valid),
	.cw_ready  (cw_ready),
	.res       (res),
	.res_valid (res_valid),
	.res_ready (res_ready)
);

`default_nettype wire

//--- verif/lgv_datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lgv_datapath_tb;

	import lgv_isa_pkg::*;
	import lgv_mem_pkg::*;

	// Upper bound on words issued by all tests
	localparam int WORD_BUDGET = 250;
	localparam int CYCLES_PER_WORD = 20;

	logic        clock;
	logic        arst_n;
	ctrl_word_t  cw;
	logic        cw_valid;
	logic        cw_ready;
	dp_result_t  res;
	logic        res_valid;
	logic        res_ready;

	int          errors;
	int          checks;
	integer      seed;

	// Reference model state
	logic [XLEN-1:0]  m_regs [0:31];
	logic [7:0]       m_ram [bit [31:0]];
	logic [31:0]      m_pc;
	flags_t           m_status;
	dp_result_t       last_exp;
	dp_result_t       last_got;

	lgv_datapath lgv_datapath_i (
		.clock     (clock),
		.arst_n    (arst_n),
		.cw        (cw),
		.cw_valid  (cw_valid),
		.cw_ready  (cw_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	function automatic logic [XLEN-1:0] read_reg(logic [4:0] idx);
		if (idx == REG_ZERO) begin
			return '0;
		end
		return m_regs[idx];
	endfunction

	// 8 KB window starting at the RAM base
	function automatic logic in_ram(logic [31:0] addr);
		return (addr >= RAM_BASE) && (addr < RAM_BASE + 32'h2000);
	endfunction

	// Expected result of one word, model state moves with it
	task automatic model_step(input ctrl_word_t w, output dp_result_t e);
		logic [XLEN-1:0]  a;
		logic [XLEN-1:0]  rb;
		logic [XLEN-1:0]  k;
		logic [XLEN-1:0]  ob;
		logic [XLEN-1:0]  f;
		logic [XLEN-1:0]  mdata;
		logic [XLEN-1:0]  data;
		logic [XLEN:0]    wide;
		logic [31:0]      ea;
		logic [31:0]      al;
		flags_t           fl;
		int               n;
		int               i;
		a = read_reg(w.sa);
		rb = read_reg(w.sb);
		case (w.cgs)
			CG_SIGN_EXT: k = {{48{w.imm[15]}}, w.imm};
			CG_SHIFT16:  k = {48'd0, w.imm} << 16;
			default:     k = {48'd0, w.imm};
		endcase
		ob = w.b_sel ? k : rb;
		fl = '0;
		case (w.fs)
			ALU_AND: f = a & ob;
			ALU_ORR: f = a | ob;
			ALU_EOR: f = a ^ ob;
			ALU_ADD: begin
				wide = a + ob + w.c0;
				f = wide[XLEN-1:0];
				fl.c = wide[XLEN];
				fl.v = (a[63] == ob[63]) && (f[63] != a[63]);
			end
			ALU_SUB: begin
				f = a - ob;
				// No borrow means carry set
				fl.c = (a >= ob);
				fl.v = (a[63] != ob[63]) && (f[63] != a[63]);
			end
			ALU_LSL: f = a << ob[5:0];
			ALU_LSR: f = a >> ob[5:0];
			default: f = ob;
		endcase
		fl.n = f[63];
		fl.z = (f == '0);
		ea = (w.as == AS_PC) ? m_pc : f[31:0];
		// Low address bits below the access size dropped
		n = 1 << w.size;
		al = ea & ~(n - 1);
		mdata = '0;
		if (w.ds == DS_MEM) begin
			if (in_ram(al)) begin
				for (i = 0; i < n; i++) begin
					mdata[8*i +: 8] = m_ram[al + i];
				end
			end
		end else if (w.mw && in_ram(al)) begin
			for (i = 0; i < n; i++) begin
				m_ram[al + i] = rb[8*i +: 8];
			end
		end
		case (w.ds)
			DS_ALU:   data = f;
			DS_REG_B: data = rb;
			DS_PC:    data = {32'd0, m_pc};
			default:  data = mdata;
		endcase
		if (w.rw && (w.da != REG_ZERO)) begin
			m_regs[w.da] = data;
		end
		if (w.sl) begin
			m_status = fl;
		end
		case (w.ps)
			PC_INCR:   m_pc = m_pc + 32'd4;
			PC_LOAD_A: m_pc = a[31:0];
			PC_BRANCH: m_pc = m_pc + (k[31:0] << 2);
			default:   m_pc = m_pc;
		endcase
		e = '{data: data, addr: ea, flags: fl, status: m_status, pc: m_pc};
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_result(input string what, input dp_result_t got,
		input dp_result_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t: %s: data %h/%h addr %h/%h", $time, what,
				got.data, exp.data, got.addr, exp.addr);
			$display("[ERROR] %0t: %s: flags %b/%b status %b/%b pc %h/%h", $time, what,
				got.flags, exp.flags, got.status, exp.status, got.pc, exp.pc);
		end
	endtask

	// Called 10 ns after a rising edge, returns at the same offset
	task automatic issue(input ctrl_word_t w);
		logic rdy;
		model_step(w, last_exp);
		cw = w;
		cw_valid = 1'b1;
		do begin
			@(negedge clock);
			rdy = cw_ready;
			@(posedge clock);
		end while (!rdy);
		#10;
		cw_valid = 1'b0;
	endtask

	task automatic collect(input string what);
		do begin
			@(negedge clock);
		end while (!res_valid);
		last_got = res;
		@(posedge clock);
		#10;
		check_result(what, last_got, last_exp);
	endtask

	task automatic send(input ctrl_word_t w, input string what);
		issue(w);
		collect(what);
	endtask

	function automatic ctrl_word_t nop_word();
		ctrl_word_t w;
		w = '0;
		w.da = REG_ZERO;
		w.sa = REG_ZERO;
		w.sb = REG_ZERO;
		w.size = SZ_DWORD;
		return w;
	endfunction

	function automatic ctrl_word_t rr_word(alu_op_e fs, logic [4:0] da, logic [4:0] sa,
		logic [4:0] sb);
		ctrl_word_t w;
		w = nop_word();
		w.fs = fs;
		w.da = da;
		w.sa = sa;
		w.sb = sb;
		w.rw = 1'b1;
		return w;
	endfunction

	function automatic ctrl_word_t ri_word(alu_op_e fs, logic [4:0] da, logic [4:0] sa,
		const_mode_e cgs, logic [15:0] imm);
		ctrl_word_t w;
		w = rr_word(fs, da, sa, REG_ZERO);
		w.b_sel = 1'b1;
		w.cgs = cgs;
		w.imm = imm;
		return w;
	endfunction

	// Address is base register plus zero-extended offset
	function automatic ctrl_word_t mem_word(logic is_load, mem_size_e sz, logic [4:0] r,
		logic [4:0] base, logic [15:0] off);
		ctrl_word_t w;
		w = ri_word(ALU_ADD, r, base, CG_ZERO_EXT, off);
		w.size = sz;
		if (is_load) begin
			w.ds = DS_MEM;
		end else begin
			w.rw = 1'b0;
			w.mw = 1'b1;
			w.sb = r;
		end
		return w;
	endfunction

	// Builds a 64-bit value 16 bits at a time
	task automatic load_reg(input logic [4:0] idx, input logic [63:0] v);
		int i;
		send(ri_word(ALU_PASS_B, idx, REG_ZERO, CG_ZERO_EXT, v[63:48]), "load high");
		for (i = 2; i >= 0; i--) begin
			send(ri_word(ALU_LSL, idx, idx, CG_ZERO_EXT, 16'd16), "load shift");
			send(ri_word(ALU_ORR, idx, idx, CG_ZERO_EXT, v[16*i +: 16]), "load merge");
		end
	endtask

	task automatic test_alu();
		ctrl_word_t  w;
		alu_op_e     op;
		int          p;
		for (p = 0; p < 2; p++) begin
			load_reg(5'd1, {$random(seed), $random(seed)});
			load_reg(5'd2, {$random(seed), $random(seed)});
			op = op.first();
			do begin
				w = rr_word(op, 5'd3, 5'd1, 5'd2);
				w.sl = 1'b1;
				send(w, op.name());
				op = op.next();
			end while (op != op.first());
			w = rr_word(ALU_ADD, 5'd3, 5'd1, 5'd2);
			w.c0 = 1'b1;
			send(w, "add with carry in");
		end
		// Signed overflow and unsigned carry corners
		load_reg(5'd1, 64'h7fff_ffff_ffff_ffff);
		load_reg(5'd2, 64'hffff_ffff_ffff_ffff);
		send(ri_word(ALU_ADD, 5'd3, 5'd1, CG_ZERO_EXT, 16'd1), "add overflow");
		check_value("add overflow flags", last_got.flags, 4'b1001);
		send(ri_word(ALU_ADD, 5'd3, 5'd2, CG_ZERO_EXT, 16'd1), "add carry");
		check_value("add carry flags", last_got.flags, 4'b0110);
		send(rr_word(ALU_SUB, 5'd3, 5'd1, 5'd2), "sub overflow");
		check_value("sub overflow flags", last_got.flags, 4'b1001);
		send(rr_word(ALU_SUB, 5'd3, 5'd2, 5'd2), "sub equal");
		check_value("sub equal flags", last_got.flags, 4'b0110);
	endtask

	task automatic test_regs_consts();
		ctrl_word_t w;
		send(ri_word(ALU_PASS_B, REG_ZERO, REG_ZERO, CG_ZERO_EXT, 16'h1234), "write xzr");
		w = nop_word();
		w.ds = DS_REG_B;
		send(w, "read xzr");
		check_value("xzr reads zero", last_got.data, 64'd0);
		send(rr_word(ALU_ORR, 5'd4, REG_ZERO, REG_ZERO), "orr xzr");
		send(ri_word(ALU_PASS_B, 5'd5, REG_ZERO, CG_ZERO_EXT, 16'h8765), "zero ext");
		check_value("zero ext", last_got.data, 64'h8765);
		send(ri_word(ALU_PASS_B, 5'd5, REG_ZERO, CG_SIGN_EXT, 16'h8765), "sign ext");
		check_value("sign ext", last_got.data, 64'hffff_ffff_ffff_8765);
		send(ri_word(ALU_PASS_B, 5'd5, REG_ZERO, CG_SHIFT16, 16'h8765), "shift16");
		check_value("shift16", last_got.data, 64'h8765_0000);
	endtask

	task automatic test_memory();
		int i;
		int sz;
		load_reg(5'd10, {32'd0, RAM_BASE});
		load_reg(5'd11, 64'h3000_0000);
		// Known contents for 0x40..0x67
		for (i = 0; i < 5; i++) begin
			load_reg(5'd1, {$random(seed), $random(seed)});
			send(mem_word(1'b0, SZ_DWORD, 5'd1, 5'd10, 16'(64 + 8 * i)), "store dword");
		end
		load_reg(5'd2, {$random(seed), $random(seed)});
		send(mem_word(1'b0, SZ_BYTE, 5'd2, 5'd10, 16'h43), "store byte");
		send(mem_word(1'b0, SZ_HALF, 5'd2, 5'd10, 16'h4b), "store half");
		send(mem_word(1'b0, SZ_WORD, 5'd2, 5'd10, 16'h55), "store word");
		for (sz = 0; sz < 4; sz++) begin
			for (i = 0; i < 3; i++) begin
				send(mem_word(1'b1, mem_size_e'(sz), 5'd5, 5'd10, 16'(64 + 11 * i)), "load");
			end
		end
		load_reg(5'd3, 64'h1122_3344_5566_77a5);
		send(mem_word(1'b0, SZ_DWORD, 5'd3, 5'd10, 16'h60), "store known");
		send(mem_word(1'b1, SZ_HALF, 5'd5, 5'd10, 16'h63), "load half known");
		check_value("little-endian half", last_got.data, 64'h5566);
		// Aliases 0x60 inside the RAM if the region check failed
		send(mem_word(1'b0, SZ_DWORD, 5'd2, 5'd11, 16'h60), "store off region");
		send(mem_word(1'b1, SZ_DWORD, 5'd5, 5'd11, 16'h60), "load off region");
		check_value("off region load", last_got.data, 64'd0);
		send(mem_word(1'b1, SZ_DWORD, 5'd5, 5'd10, 16'h60), "reload known");
		check_value("ram unchanged", last_got.data, 64'h1122_3344_5566_77a5);
	endtask

	task automatic test_pc();
		ctrl_word_t w;
		w = nop_word();
		w.ps = PC_INCR;
		w.ds = DS_PC;
		w.as = AS_PC;
		repeat (3) begin
			send(w, "pc incr");
		end
		check_value("addr follows pc", last_got.addr, 32'd8);
		load_reg(5'd4, 64'h1000);
		w.ps = PC_LOAD_A;
		w.sa = 5'd4;
		send(w, "pc load");
		check_value("pc load", last_got.pc, 32'h1000);
		w = nop_word();
		w.ps = PC_BRANCH;
		w.ds = DS_PC;
		w.cgs = CG_SIGN_EXT;
		w.imm = 16'hfffe;
		send(w, "branch back");
		check_value("branch back", last_got.pc, 32'h0ff8);
		w.imm = 16'h0010;
		send(w, "branch forward");
		check_value("branch forward", last_got.pc, 32'h1038);
	endtask

	task automatic test_status();
		ctrl_word_t w;
		w = ri_word(ALU_SUB, 5'd6, REG_ZERO, CG_ZERO_EXT, 16'd1);
		w.sl = 1'b1;
		send(w, "status load");
		check_value("status negative", last_got.status, 4'b1000);
		send(ri_word(ALU_ADD, 5'd6, REG_ZERO, CG_ZERO_EXT, 16'd0), "status hold");
		check_value("live flags", last_got.flags, 4'b0100);
		check_value("status held", last_got.status, 4'b1000);
		w.imm = 16'd0;
		send(w, "status reload");
		check_value("status zero carry", last_got.status, 4'b0110);
	endtask

	task automatic test_backpressure();
		ctrl_word_t  w;
		dp_result_t  held;
		res_ready = 1'b0;
		issue(ri_word(ALU_PASS_B, 5'd7, REG_ZERO, CG_ZERO_EXT, 16'h0abc));
		held = last_exp;
		w = ri_word(ALU_ADD, 5'd7, 5'd7, CG_ZERO_EXT, 16'd1);
		cw = w;
		cw_valid = 1'b1;
		repeat (5) begin
			@(negedge clock);
			check_value("stalled ready", cw_ready, 1'b0);
			check_value("stalled valid", res_valid, 1'b1);
			check_result("stalled result", res, held);
			@(posedge clock);
		end
		#10;
		res_ready = 1'b1;
		send(w, "after stall");
		check_value("after stall", last_got.data, 64'h0abd);
		// Load then dependent add, back to back
		load_reg(5'd8, 64'h0123_4567_89ab_cdef);
		send(mem_word(1'b0, SZ_DWORD, 5'd8, 5'd10, 16'h100), "store for load");
		issue(mem_word(1'b1, SZ_DWORD, 5'd9, 5'd10, 16'h100));
		issue(ri_word(ALU_ADD, 5'd9, 5'd9, CG_ZERO_EXT, 16'd1));
		collect("dependent add");
		check_value("dependent add", last_got.data, 64'h0123_4567_89ab_cdf0);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		seed = 32'hf40d_a001;
		arst_n = 1'b0;
		cw = '0;
		cw_valid = 1'b0;
		res_ready = 1'b1;
		m_pc = '0;
		m_status = '0;
		repeat (8) @(posedge clock);
		#10;
		arst_n = 1'b1;
		@(negedge clock);
		check_value("ready after reset", cw_ready, 1'b1);
		check_value("valid after reset", res_valid, 1'b0);
		check_value("pc after reset", res.pc, 32'd0);
		check_value("status after reset", res.status, 4'd0);
		@(posedge clock);
		#10;
		test_alu();
		test_regs_consts();
		test_memory();
		test_pc();
		test_status();
		test_backpressure();
		errors += lgv_datapath_i.lgv_datapath_props_i.fail_count;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Budget covers reset plus every issued word
	initial begin
		repeat (8 + WORD_BUDGET * CYCLES_PER_WORD) @(posedge clock);
		$display("Timeout: the tests did not finish within the cycle budget");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- lgv_dp.f
hw/lgv_mem_pkg.sv
hw/lgv_isa_pkg.sv
hw/lgv_regfile.sv
hw/lgv_alu.sv
hw/lgv_pc_unit.sv
hw/lgv_ram.sv
hw/lgv_datapath.sv
verif/lgv_datapath_props.sv
verif/lgv_datapath_tb.sv
